/* run_sim.sh */
#!/bin/sh
# compile and run the rvv_lsu_decode testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_rvv_lsu_decode \
  -f rvv_lsu_decode.f -o sim_tb
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/sim_tb)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qx "TEST OK"; then
  exit 0
fi
exit 1

/* rvv_backend_decode.sv */
`timescale 1ns/1ns
`include "rvv_lsu_decode_params.svh"

module rvv_backend_decode import rvv_lsu_decode_pkg::*;
(
  input   logic        clk,
  input   logic        rst_n,
  input   logic        inst_valid,
  input   INST_t       inst,
  input   logic        uop_pop,
  output  logic        inst_done,
  output  logic        inst_illegal,
  output  logic        uop_out_valid,
  output  UOP_QUEUE_t  uop_out,
  output  logic        queue_full
);

  uop_index_t                          uop_index_remain;
  logic       [`NUM_DE_UOP-1:0]        lsu_uop_valid;
  UOP_QUEUE_t [`NUM_DE_UOP-1:0]        lsu_uop;
  logic                                inst_illegal_comb;
  logic       [`NUM_DE_UOP-1:0]        push_valid;
  UOP_QUEUE_t [`NUM_DE_UOP-1:0]        push_uop;
  logic [`UOP_QUEUE_CNT_WIDTH-1:0]     free_count;

  rvv_backend_decode_ctrl u_ctrl (
    .clk               (clk),
    .rst_n             (rst_n),
    .inst_valid        (inst_valid),
    .uop_valid_in      (lsu_uop_valid),
    .uop_in            (lsu_uop),
    .inst_illegal_comb (inst_illegal_comb),
    .free_count        (free_count),
    .uop_index_remain  (uop_index_remain),
    .push_valid        (push_valid),
    .push_uop          (push_uop),
    .inst_done         (inst_done),
    .inst_illegal      (inst_illegal)
  );

  rvv_backend_decode_unit_lsu u_lsu (
    .inst_valid        (inst_valid),
    .inst              (inst),
    .uop_index_remain  (uop_index_remain),
    .uop_valid         (lsu_uop_valid),
    .uop               (lsu_uop),
    .inst_illegal_comb (inst_illegal_comb)
  );

  rvv_backend_uop_queue u_queue (
    .clk               (clk),
    .rst_n             (rst_n),
    .push_valid        (push_valid),
    .push_uop          (push_uop),
    .uop_pop           (uop_pop),
    .uop_out_valid     (uop_out_valid),
    .uop_out           (uop_out),
    .free_count        (free_count),
    .queue_full        (queue_full)
  );

endmodule

/* rvv_backend_decode_ctrl.sv */
`timescale 1ns/1ns
`include "rvv_lsu_decode_params.svh"

module rvv_backend_decode_ctrl import rvv_lsu_decode_pkg::*;
(
  clk,
  rst_n,
  inst_valid,
  uop_valid_in,
  uop_in,
  inst_illegal_comb,
  free_count,
  uop_index_remain,
  push_valid,
  push_uop,
  inst_done,
  inst_illegal
);

  input   logic                                 clk;
  input   logic                                 rst_n;
  input   logic                                 inst_valid;
  input   logic       [`NUM_DE_UOP-1:0]         uop_valid_in;
  input   UOP_QUEUE_t [`NUM_DE_UOP-1:0]         uop_in;
  input   logic                                 inst_illegal_comb;
  input   logic [`UOP_QUEUE_CNT_WIDTH-1:0]      free_count;

  output  uop_index_t                           uop_index_remain;
  output  logic       [`NUM_DE_UOP-1:0]         push_valid;
  output  UOP_QUEUE_t [`NUM_DE_UOP-1:0]         push_uop;
  output  logic                                 inst_done;
  output  logic                                 inst_illegal;

  localparam int CNT_W = `UOP_QUEUE_CNT_WIDTH;

  logic        inst_legal;
  logic        has_room;
  logic        last_pushed;
  logic        nothing_left;    // every remaining uop sits below vstart
  uop_index_t  index_next;

  assign inst_legal   = inst_valid & ~inst_illegal_comb;
  assign has_room     = free_count >= CNT_W'(`NUM_DE_UOP);   // whole pair must fit
  assign nothing_left = inst_legal & (uop_valid_in == '0);

  assign push_valid   = (inst_legal & has_room) ? uop_valid_in : '0;
  assign push_uop     = uop_in;

  always_comb begin
    last_pushed = 1'b0;
    index_next  = uop_index_remain;
    for (int k = 0; k < `NUM_DE_UOP; k++) begin
      if (push_valid[k]) begin
        last_pushed = last_pushed | uop_in[k].last_uop;
        index_next  = uop_in[k].uop_index + 1'b1;    // resume after highest pushed
      end
    end
  end

  // illegal ops finish at once, nothing gets queued
  assign inst_illegal = inst_valid & inst_illegal_comb;
  assign inst_done    = inst_illegal | nothing_left | last_pushed;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      uop_index_remain <= '0;
    end else if (inst_done) begin
      uop_index_remain <= '0;
    end else if (|push_valid) begin
      uop_index_remain <= index_next;
    end
  end

endmodule

/* rvv_backend_decode_unit_lsu.sv */
`timescale 1ns/1ns
`include "rvv_lsu_decode_params.svh"

module rvv_backend_decode_unit_lsu import rvv_lsu_decode_pkg::*;
(
  inst_valid,
  inst,
  uop_index_remain,
  uop_valid,
  uop,
  inst_illegal_comb
);

  input   logic                               inst_valid;
  input   INST_t                              inst;
  input   uop_index_t                         uop_index_remain;

  output  logic       [`NUM_DE_UOP-1:0]       uop_valid;
  output  UOP_QUEUE_t [`NUM_DE_UOP-1:0]       uop;
  output  logic                               inst_illegal_comb;

  // field positions inside the encoding field
  localparam int VD_LO      = 2;
  localparam int FUNCT3_LO  = VD_LO + `VD_WIDTH;
  localparam int RS1_LO     = FUNCT3_LO + `FUNCT3_WIDTH;
  localparam int VS2_LO     = RS1_LO + `VS1_WIDTH;
  localparam int VM_LO      = VS2_LO + `VS2_WIDTH;
  localparam int FUNCT6_LO  = VM_LO + `VM_WIDTH;
  localparam int VLENB_LOG2 = $clog2(`VLEN/8);

  logic [1:0]                      inst_class;     // 00 load, 01 store
  FUNCT6_u                         funct6_lsu;
  logic [`VM_WIDTH-1:0]            inst_vm;
  reg_index_t                      inst_vs2;
  logic [`FUNCT3_WIDTH-1:0]        inst_funct3;
  reg_index_t                      inst_vd;
  logic [`VTYPE_VILL_WIDTH-1:0]    vill;
  logic [`VTYPE_VSEW_WIDTH-1:0]    vsew;
  logic [`VTYPE_VLMUL_WIDTH-1:0]   vlmul;
  vstart_t                         vstart;

  logic                            is_indexed;
  EEW_e                            eew_width;
  EEW_e                            eew_sew;
  EEW_e                            eew_vd;
  EEW_e                            eew_vs2;
  logic signed [3:0]               lmul_log2;
  logic signed [3:0]               emul_vd_log2;
  logic signed [3:0]               emul_vs2_log2;
  logic [1:0]                      cl_vd;
  logic [1:0]                      cl_vs2;
  logic [1:0]                      cl_max;
  emul_t                           emul_vd;
  emul_t                           emul_vs2;
  emul_t                           emul_max;
  logic [2:0]                      vd_mask;
  logic [2:0]                      vs2_mask;
  logic                            lmul_ok;
  logic                            emul_ok;
  logic                            align_ok;
  logic                            legal;
  vstart_t                         uop_vstart;
  vstart_t                         uop_index_start;
  vstart_t [`NUM_DE_UOP-1:0]       uop_index_current;   // wider than uop_index_t, no wrap

  function automatic logic signed [3:0] eew_log2(input EEW_e eew);
    case (eew)
      EEW16:   eew_log2 = 4'sd1;
      EEW32:   eew_log2 = 4'sd2;
      default: eew_log2 = 4'sd0;
    endcase
  endfunction

  // fractional emul still occupies one register
  function automatic logic [1:0] clip_log2(input logic signed [3:0] e);
    clip_log2 = (e > 4'sd0) ? e[1:0] : 2'd0;
  endfunction

  function automatic logic emul_in_range(input logic signed [3:0] e);
    emul_in_range = (e >= -4'sd3) && (e <= 4'sd3);
  endfunction

  assign inst_class  = inst.inst[1:0];
  assign inst_vd     = inst.inst[VD_LO +: `VD_WIDTH];
  assign inst_funct3 = inst.inst[FUNCT3_LO +: `FUNCT3_WIDTH];
  assign inst_vs2    = inst.inst[VS2_LO +: `VS2_WIDTH];
  assign inst_vm     = inst.inst[VM_LO +: `VM_WIDTH];
  assign funct6_lsu.bits = inst.inst[FUNCT6_LO +: `FUNCT6_WIDTH];
  assign vill        = inst.vector_csr.vtype.vill;
  assign vsew        = inst.vector_csr.vtype.vsew;
  assign vlmul       = inst.vector_csr.vtype.vlmul;
  assign vstart      = inst.vector_csr.vstart;

  assign is_indexed  = funct6_lsu.lsu.mop[0];    // 01 and 11

  always_comb begin
    case (inst_funct3)
      3'b000:  eew_width = EEW8;
      3'b101:  eew_width = EEW16;
      3'b110:  eew_width = EEW32;
      default: eew_width = EEW_NONE;
    endcase
    case (vsew)
      3'b000:  eew_sew = EEW8;
      3'b001:  eew_sew = EEW16;
      3'b010:  eew_sew = EEW32;
      default: eew_sew = EEW_NONE;
    endcase
  end

  always_comb begin
    lmul_ok = 1'b1;
    case (vlmul)
      3'b110:  lmul_log2 = -4'sd2;
      3'b111:  lmul_log2 = -4'sd1;
      3'b000:  lmul_log2 = 4'sd0;
      3'b001:  lmul_log2 = 4'sd1;
      3'b010:  lmul_log2 = 4'sd2;
      3'b011:  lmul_log2 = 4'sd3;
      default: begin
        lmul_log2 = 4'sd0;
        lmul_ok   = 1'b0;   // 1/8 and reserved
      end
    endcase
  end

  // indexed: data follows sew/lmul, index takes the width field
  assign eew_vd        = is_indexed ? eew_sew : eew_width;
  assign eew_vs2       = is_indexed ? eew_width : EEW_NONE;
  assign emul_vs2_log2 = eew_log2(eew_width) - eew_log2(eew_sew) + lmul_log2;
  assign emul_vd_log2  = is_indexed ? lmul_log2 : emul_vs2_log2;

  assign cl_vd    = clip_log2(emul_vd_log2);
  assign cl_vs2   = is_indexed ? clip_log2(emul_vs2_log2) : 2'd0;
  assign cl_max   = (cl_vd > cl_vs2) ? cl_vd : cl_vs2;
  assign emul_vd  = emul_t'(1) << cl_vd;
  assign emul_vs2 = emul_t'(1) << cl_vs2;
  assign emul_max = emul_t'(1) << cl_max;

  assign vd_mask  = 3'(emul_vd - 4'd1);
  assign vs2_mask = 3'(emul_vs2 - 4'd1);
  assign emul_ok  = emul_in_range(emul_vd_log2) & (~is_indexed | emul_in_range(emul_vs2_log2));
  assign align_ok = ((inst_vd[2:0] & vd_mask) == 3'd0) &
                    (~is_indexed | ((inst_vs2[2:0] & vs2_mask) == 3'd0));

  assign legal = ~vill[0] & (eew_sew != EEW_NONE) & (eew_width != EEW_NONE) & lmul_ok &
                 (funct6_lsu.lsu.nf == 3'd0) & ~funct6_lsu.lsu.mew & ~inst_class[1] &
                 emul_ok & align_ok;

  assign inst_illegal_comb = inst_valid & ~legal;

  // registers wholly below vstart are skipped
  assign uop_vstart      = vstart >> (VLENB_LOG2 - eew_log2(eew_vd));
  assign uop_index_start = (vstart_t'(uop_index_remain) > uop_vstart) ?
                           vstart_t'(uop_index_remain) : uop_vstart;

  always_comb begin
    for (int k = 0; k < `NUM_DE_UOP; k++) begin
      uop_index_current[k] = uop_index_start + vstart_t'(k);
      uop_valid[k] = inst_valid & legal & (uop_index_current[k] < vstart_t'(emul_max));

      uop[k].uop_pc    = inst.inst_pc;
      uop[k].is_store  = inst_class[0];
      uop[k].kind      = LSU_KIND_e'(funct6_lsu.lsu.mop);
      uop[k].vm        = inst_vm[0];
      uop[k].vd_index  = inst_vd + reg_index_t'(uop_index_current[k] >> (cl_max - cl_vd));
      uop[k].vs2_index = is_indexed ?
                         inst_vs2 + reg_index_t'(uop_index_current[k] >> (cl_max - cl_vs2)) :
                         inst_vs2;
      uop[k].eew_vd    = eew_vd;
      uop[k].eew_vs2   = eew_vs2;
      uop[k].rs1_data  = inst.rs1_data;
      uop[k].vl        = inst.vector_csr.vl;
      uop[k].vstart    = vstart;
      uop[k].uop_index = uop_index_t'(uop_index_current[k]);
      uop[k].first_uop = uop_index_current[k] == uop_vstart;   // first one left after skipping
      uop[k].last_uop  = uop_index_current[k] == vstart_t'(emul_max - 4'd1);
    end
  end

endmodule

/* rvv_backend_uop_queue.sv */
`timescale 1ns/1ns
`include "rvv_lsu_decode_params.svh"

module rvv_backend_uop_queue import rvv_lsu_decode_pkg::*;
(
  clk,
  rst_n,
  push_valid,
  push_uop,
  uop_pop,
  uop_out_valid,
  uop_out,
  free_count,
  queue_full
);

  input   logic                                 clk;
  input   logic                                 rst_n;
  input   logic       [`NUM_DE_UOP-1:0]         push_valid;
  input   UOP_QUEUE_t [`NUM_DE_UOP-1:0]         push_uop;
  input   logic                                 uop_pop;

  output  logic                                 uop_out_valid;
  output  UOP_QUEUE_t                           uop_out;
  output  logic [`UOP_QUEUE_CNT_WIDTH-1:0]      free_count;
  output  logic                                 queue_full;

  localparam int PTR_W = $clog2(`UOP_QUEUE_DEPTH);
  localparam int CNT_W = `UOP_QUEUE_CNT_WIDTH;

  UOP_QUEUE_t          mem [`UOP_QUEUE_DEPTH];
  logic [PTR_W-1:0]    rptr;
  logic [PTR_W-1:0]    wptr;
  logic [PTR_W-1:0]    wptr_p1;
  logic [CNT_W-1:0]    count;
  logic [1:0]          push_num;
  logic                pop_en;
  UOP_QUEUE_t          wr_data0;
  UOP_QUEUE_t          wr_data1;

  assign push_num = {1'b0, push_valid[0]} + {1'b0, push_valid[1]};
  assign pop_en   = uop_pop & (count != '0);   // pop on empty is dropped
  assign wptr_p1  = wptr + 1'b1;

  // compact the pair, a lone slot-1 uop goes to wptr
  assign wr_data0 = push_valid[0] ? push_uop[0] : push_uop[1];
  assign wr_data1 = push_uop[1];

  always_ff @(posedge clk) begin
    if (push_num != 2'd0) begin
      mem[wptr] <= wr_data0;
    end
    if (push_num == 2'd2) begin
      mem[wptr_p1] <= wr_data1;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rptr  <= '0;
      wptr  <= '0;
      count <= '0;
    end else begin
      wptr  <= wptr + PTR_W'(push_num);
      rptr  <= rptr + PTR_W'(pop_en);
      count <= count + CNT_W'(push_num) - CNT_W'(pop_en);
    end
  end

  assign uop_out_valid = count != '0;
  assign uop_out       = mem[rptr];                  // head entry
  assign free_count    = CNT_W'(`UOP_QUEUE_DEPTH) - count;
  assign queue_full    = count == CNT_W'(`UOP_QUEUE_DEPTH);

endmodule

/* rvv_lsu_decode.f */
+incdir+.
rvv_lsu_decode_pkg.sv
rvv_backend_decode_unit_lsu.sv
rvv_backend_decode_ctrl.sv
rvv_backend_uop_queue.sv
rvv_backend_decode.sv
tb_rvv_lsu_decode.sv

/* rvv_lsu_decode_params.svh */
`ifndef RVV_LSU_DECODE_PARAMS_SVH
`define RVV_LSU_DECODE_PARAMS_SVH

// scalar and vector data widths
`define XLEN                32
`define VLEN                128
`define PC_WIDTH            32

// decode and queue sizing
`define NUM_DE_UOP          2     // uops produced per cycle
`define UOP_INDEX_WIDTH     3     // up to 8 uops per instruction
`define UOP_QUEUE_DEPTH     8
`define UOP_QUEUE_CNT_WIDTH 4     // occupancy and free count, 0..depth

// vector csr fields
`define VSTART_WIDTH        7
`define VL_WIDTH            8

// encoding fields of a vector memory instruction
`define FUNCT6_WIDTH        6
`define VM_WIDTH            1
`define VS2_WIDTH           5
`define VS1_WIDTH           5
`define UMOP_WIDTH          5
`define IMM_WIDTH           5
`define FUNCT3_WIDTH        3
`define VD_WIDTH            5
`define RD_WIDTH            5

// bits 31:7 of the encoding plus the 2-bit opcode class below them
`define INST_WIDTH          (`FUNCT6_WIDTH + `VM_WIDTH + `UMOP_WIDTH + `IMM_WIDTH + \
                             `FUNCT3_WIDTH + `RD_WIDTH + 2)

// vtype fields
`define VTYPE_VILL_WIDTH    1
`define VTYPE_VSEW_WIDTH    3
`define VTYPE_VLMUL_WIDTH   3

`endif

/* rvv_lsu_decode_pkg.sv */
`include "rvv_lsu_decode_params.svh"

package rvv_lsu_decode_pkg;

  typedef logic [`VD_WIDTH-1:0]          reg_index_t;
  typedef logic [`UOP_INDEX_WIDTH-1:0]   uop_index_t;
  typedef logic [`PC_WIDTH-1:0]          pc_t;
  typedef logic [`XLEN-1:0]              xdata_t;
  typedef logic [`VSTART_WIDTH-1:0]      vstart_t;
  typedef logic [`VL_WIDTH-1:0]          vl_t;
  typedef logic [`VTYPE_VLMUL_WIDTH:0]   emul_t;     // register count, 1..8

  typedef enum logic [1:0] {
    EEW8,
    EEW16,
    EEW32,
    EEW_NONE
  } EEW_e;

  // values follow the mop field of the encoding
  typedef enum logic [1:0] {
    UNIT      = 2'b00,
    IDX_UNORD = 2'b01,
    STRIDED   = 2'b10,
    IDX_ORD   = 2'b11
  } LSU_KIND_e;

  typedef struct packed {
    logic [`VTYPE_VILL_WIDTH-1:0]  vill;
    logic [`VTYPE_VSEW_WIDTH-1:0]  vsew;
    logic [`VTYPE_VLMUL_WIDTH-1:0] vlmul;
  } VTYPE_t;

  typedef struct packed {
    VTYPE_t  vtype;
    vl_t     vl;
    vstart_t vstart;
  } VECTOR_CSR_t;

  typedef struct packed {
    pc_t                    inst_pc;
    logic [`INST_WIDTH-1:0] inst;        // encoding 31:7 at 26:2, opcode class at 1:0
    VECTOR_CSR_t            vector_csr;
    xdata_t                 rs1_data;
  } INST_t;

  typedef union packed {
    logic [`FUNCT6_WIDTH-1:0] bits;
    struct packed {
      logic [2:0] nf;
      logic       mew;
      logic [1:0] mop;
    } lsu;
  } FUNCT6_u;

  typedef struct packed {
    pc_t        uop_pc;
    logic       is_store;
    LSU_KIND_e  kind;
    logic       vm;
    reg_index_t vd_index;      // data register, load dest or store source
    reg_index_t vs2_index;
    EEW_e       eew_vd;
    EEW_e       eew_vs2;
    xdata_t     rs1_data;
    vl_t        vl;
    vstart_t    vstart;
    uop_index_t uop_index;
    logic       first_uop;
    logic       last_uop;
  } UOP_QUEUE_t;

endpackage

/* tb_rvv_lsu_decode.sv */
`timescale 1ns/1ns
`include "rvv_lsu_decode_params.svh"

module tb_rvv_lsu_decode import rvv_lsu_decode_pkg::*;
();

  localparam int NUM_TESTS = 6;
  localparam int CLK_HALF  = 5;

  logic       clk;
  logic       rst_n;
  logic       inst_valid;
  INST_t      inst;
  logic       uop_pop;
  logic       inst_done;
  logic       inst_illegal;
  logic       uop_out_valid;
  UOP_QUEUE_t uop_out;
  logic       queue_full;

  UOP_QUEUE_t exp_q[$];      // expected entries in queue order
  logic       pop_en;
  int         errors;
  int         checks;
  int         tests_run;
  int         done_pulses;
  int         popped;
  integer     seed;
  pc_t        next_pc;

  rvv_backend_decode dut0 (
    .clk           (clk),
    .rst_n         (rst_n),
    .inst_valid    (inst_valid),
    .inst          (inst),
    .uop_pop       (uop_pop),
    .inst_done     (inst_done),
    .inst_illegal  (inst_illegal),
    .uop_out_valid (uop_out_valid),
    .uop_out       (uop_out),
    .queue_full    (queue_full)
  );

  initial clk = 1'b0;
  always #CLK_HALF clk = ~clk;

  task automatic check_bit(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      $display("[FAIL] %s got %0h expected %0h", name, got, exp);
      errors++;
    end
  endtask

  task automatic check_count(input string name, input uop_index_t got, input uop_index_t exp);
    checks++;
    if (got !== exp) begin
      $display("[FAIL] %s got %0h expected %0h", name, got, exp);
      errors++;
    end
  endtask

  task automatic compare_field(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("[FAIL] %s got %0h expected %0h", name, got, exp);
    end
  endtask

  task automatic check_uop(input string name, input UOP_QUEUE_t got, input UOP_QUEUE_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      compare_field({name, ".uop_pc"}, got.uop_pc, exp.uop_pc);
      compare_field({name, ".is_store"}, got.is_store, exp.is_store);
      compare_field({name, ".kind"}, got.kind, exp.kind);
      compare_field({name, ".vm"}, got.vm, exp.vm);
      compare_field({name, ".vd_index"}, got.vd_index, exp.vd_index);
      compare_field({name, ".vs2_index"}, got.vs2_index, exp.vs2_index);
      compare_field({name, ".eew_vd"}, got.eew_vd, exp.eew_vd);
      compare_field({name, ".eew_vs2"}, got.eew_vs2, exp.eew_vs2);
      compare_field({name, ".rs1_data"}, got.rs1_data, exp.rs1_data);
      compare_field({name, ".vl"}, got.vl, exp.vl);
      compare_field({name, ".vstart"}, got.vstart, exp.vstart);
      compare_field({name, ".uop_index"}, got.uop_index, exp.uop_index);
      compare_field({name, ".first_uop"}, got.first_uop, exp.first_uop);
      compare_field({name, ".last_uop"}, got.last_uop, exp.last_uop);
    end
  endtask

  function automatic EEW_e to_eew(input int bits);
    case (bits)
      8:       to_eew = EEW8;
      16:      to_eew = EEW16;
      default: to_eew = EEW32;
    endcase
  endfunction

  // kind follows the two mop bits of the encoding
  function automatic LSU_KIND_e to_kind(input logic [1:0] mop);
    case (mop)
      2'b00:   to_kind = UNIT;
      2'b01:   to_kind = IDX_UNORD;
      2'b10:   to_kind = STRIDED;
      default: to_kind = IDX_ORD;
    endcase
  endfunction

  // encoding bit b of the instruction sits at position b-5
  function automatic INST_t make_inst(input logic [1:0] cls, input logic [1:0] mop,
      input reg_index_t vs2, input logic [2:0] width, input reg_index_t vd,
      input logic [2:0] vsew, input logic [2:0] vlmul, input vstart_t vstart,
      input logic vill, input logic [2:0] nf);
    INST_t i;
    i.inst_pc = next_pc;
    i.inst = {nf, 1'b0, mop, 1'b1, vs2, 5'd1, width, vd, cls};
    i.vector_csr.vtype.vill = vill;
    i.vector_csr.vtype.vsew = vsew;
    i.vector_csr.vtype.vlmul = vlmul;
    i.vector_csr.vl = vl_t'($random(seed));
    i.vector_csr.vstart = vstart;
    i.rs1_data = xdata_t'($random(seed));
    next_pc = next_pc + 32'd4;
    return i;
  endfunction

  // reference split with emul kept in eighths of a register
  task automatic build_expected(input INST_t i);
    UOP_QUEUE_t u;
    logic [1:0] mop;
    int eew_w;
    int sew;
    int lmul8;
    int d8;
    int x8;
    int deew;
    int dregs;
    int xregs;
    int nmax;
    int ustart;
    mop = i.inst[22:21];
    case (i.inst[9:7])
      3'b000:  eew_w = 8;
      3'b101:  eew_w = 16;
      default: eew_w = 32;
    endcase
    sew = 8 << i.vector_csr.vtype.vsew;
    case (i.vector_csr.vtype.vlmul)
      3'b110:  lmul8 = 2;
      3'b111:  lmul8 = 4;
      3'b001:  lmul8 = 16;
      3'b010:  lmul8 = 32;
      3'b011:  lmul8 = 64;
      default: lmul8 = 8;
    endcase
    if (mop[0]) begin
      d8 = lmul8;
      x8 = eew_w * lmul8 / sew;
      deew = sew;   // data follows sew when indexed
    end else begin
      d8 = eew_w * lmul8 / sew;
      x8 = 0;
      deew = eew_w;
    end
    dregs = (d8 < 8) ? 1 : d8 / 8;
    xregs = (x8 < 8) ? 1 : x8 / 8;
    nmax = (dregs > xregs) ? dregs : xregs;
    ustart = int'(i.vector_csr.vstart) / (`VLEN / deew);
    for (int k = ustart; k < nmax; k++) begin
      u.uop_pc = i.inst_pc;
      u.is_store = (i.inst[1:0] == 2'b01);
      u.kind = to_kind(mop);
      u.vm = i.inst[20];
      u.vd_index = i.inst[6:2] + reg_index_t'(k * dregs / nmax);
      u.vs2_index = mop[0] ? i.inst[19:15] + reg_index_t'(k * xregs / nmax) : i.inst[19:15];
      u.eew_vd = to_eew(deew);
      u.eew_vs2 = mop[0] ? to_eew(eew_w) : EEW_NONE;
      u.rs1_data = i.rs1_data;
      u.vl = i.vector_csr.vl;
      u.vstart = i.vector_csr.vstart;
      u.uop_index = uop_index_t'(k);
      u.first_uop = (k == ustart);
      u.last_uop = (k == nmax - 1);
      exp_q.push_back(u);
    end
  endtask

  // consumer pops the head whenever enabled
  always @(posedge clk) begin
    #1;
    uop_pop = pop_en & uop_out_valid;
  end

  always @(negedge clk) begin
    if (uop_pop === 1'b1) begin
      popped++;
      if (exp_q.size() == 0) begin
        $display("queue delivered an entry that was never expected, index %0d",
                 uop_out.uop_index);
        errors++;
      end else begin
        check_uop("uop_out", uop_out, exp_q.pop_front());
      end
    end
    if (inst_done === 1'b1) done_pulses++;
  end

  task automatic set_pop(input logic en);
    @(negedge clk);
    pop_en = en;
  endtask

  task automatic start_inst(input INST_t i, input bit legal);
    @(posedge clk);
    #1;
    if (legal) build_expected(i);
    inst = i;
    inst_valid = 1'b1;
  endtask

  // holds the instruction until inst_done and returns the inst_illegal seen with it
  task automatic wait_done(input int max_cycles, output logic ill);
    int n;
    bit seen;
    n = 0;
    seen = 0;
    ill = 1'b0;
    while (!seen && n < max_cycles) begin
      @(negedge clk);
      if (inst_done === 1'b1) begin
        seen = 1;
        ill = inst_illegal;
      end
      n++;
    end
    @(posedge clk);
    #1;
    inst_valid = 1'b0;
    if (!seen) begin
      $display("inst_done did not arrive within %0d cycles", max_cycles);
      errors++;
    end
  endtask

  task automatic drain(input int max_cycles);
    int n;
    n = 0;
    while ((exp_q.size() != 0 || uop_out_valid) && n < max_cycles) begin
      @(posedge clk);
      #2;
      n++;
    end
    if (n >= max_cycles) begin
      $display("queue did not drain, %0d expected entries still missing", exp_q.size());
      errors++;
    end
  endtask

  task automatic run_inst(input INST_t i, input bit legal, input uop_index_t n_uops);
    int d0;
    int p0;
    logic ill;
    d0 = done_pulses;
    p0 = popped;
    start_inst(i, legal);
    wait_done(20, ill);
    check_bit("inst_illegal", ill, ~legal);
    drain(40);
    check_count("inst_done pulses", uop_index_t'(done_pulses - d0), 3'd1);
    check_count("uops popped", uop_index_t'(popped - p0), n_uops);
  endtask

  task automatic finish_test(input string name, input int err_start);
    tests_run++;
    $display("test %0d %s finished with %0d errors", tests_run, name, errors - err_start);
  endtask

  task automatic test_unit_stride_frac();
    int e0;
    e0 = errors;
    run_inst(make_inst(2'b00, 2'b00, 5'd0, 3'b000, 5'd4, 3'b010, 3'b001, 7'd0, 1'b0, 3'd0),
             1'b1, 3'd1);
    finish_test("unit-stride fractional emul", e0);
  endtask

  task automatic test_strided_store_bad_index();
    int e0;
    e0 = errors;
    run_inst(make_inst(2'b01, 2'b10, 5'd3, 3'b110, 5'd8, 3'b000, 3'b000, 7'd0, 1'b0, 3'd0),
             1'b1, 3'd4);
    // index emul 16 is out of range
    run_inst(make_inst(2'b00, 2'b01, 5'd0, 3'b101, 5'd0, 3'b000, 3'b011, 7'd0, 1'b0, 3'd0),
             1'b0, 3'd0);
    finish_test("strided store, bad index emul", e0);
  endtask

  task automatic test_indexed_ordered();
    int e0;
    e0 = errors;
    run_inst(make_inst(2'b00, 2'b11, 5'd5, 3'b000, 5'd12, 3'b010, 3'b010, 7'd0, 1'b0, 3'd0),
             1'b1, 3'd4);
    finish_test("indexed ordered load", e0);
  endtask

  task automatic test_vstart_skip();
    int e0;
    e0 = errors;
    run_inst(make_inst(2'b00, 2'b00, 5'd0, 3'b101, 5'd4, 3'b001, 3'b010, 7'd17, 1'b0, 3'd0),
             1'b1, 3'd2);   // uops 0 and 1 lie below element 17
    // vstart past the only register leaves nothing to push
    run_inst(make_inst(2'b00, 2'b00, 5'd0, 3'b000, 5'd4, 3'b000, 3'b000, 7'd20, 1'b0, 3'd0),
             1'b1, 3'd0);
    finish_test("vstart skipping", e0);
  endtask

  task automatic test_illegal_cases();
    int e0;
    e0 = errors;
    run_inst(make_inst(2'b00, 2'b00, 5'd0, 3'b000, 5'd4, 3'b010, 3'b001, 7'd0, 1'b1, 3'd0),
             1'b0, 3'd0);
    run_inst(make_inst(2'b00, 2'b00, 5'd0, 3'b000, 5'd4, 3'b010, 3'b001, 7'd0, 1'b0, 3'd1),
             1'b0, 3'd0);
    run_inst(make_inst(2'b00, 2'b00, 5'd0, 3'b000, 5'd3, 3'b000, 3'b001, 7'd0, 1'b0, 3'd0),
             1'b0, 3'd0);
    run_inst(make_inst(2'b00, 2'b00, 5'd0, 3'b111, 5'd4, 3'b010, 3'b001, 7'd0, 1'b0, 3'd0),
             1'b0, 3'd0);
    finish_test("illegal encodings", e0);
  endtask

  task automatic test_back_pressure();
    int e0;
    int d0;
    int p0;
    logic ill;
    logic early_done;
    e0 = errors;
    d0 = done_pulses;
    p0 = popped;
    early_done = 1'b0;
    set_pop(1'b0);
    start_inst(make_inst(2'b00, 2'b00, 5'd0, 3'b000, 5'd0, 3'b000, 3'b011, 7'd0, 1'b0, 3'd0),
               1'b1);
    wait_done(20, ill);
    check_bit("inst_illegal", ill, 1'b0);
    start_inst(make_inst(2'b01, 2'b10, 5'd2, 3'b000, 5'd16, 3'b000, 3'b011, 7'd0, 1'b0, 3'd0),
               1'b1);
    repeat (6) begin
      @(negedge clk);
      if (inst_done === 1'b1) early_done = 1'b1;
    end
    check_bit("inst_done", early_done, 1'b0);
    check_bit("queue_full", queue_full, 1'b1);
    set_pop(1'b1);
    wait_done(40, ill);
    check_bit("inst_illegal", ill, 1'b0);
    drain(40);
    check_count("inst_done pulses", uop_index_t'(done_pulses - d0), 3'd2);
    check_bit("all 16 entries popped", popped - p0 == 16, 1'b1);
    finish_test("back-pressure", e0);
  endtask

  initial begin
    #(NUM_TESTS * 200 * 2 * CLK_HALF);
    $display("watchdog expired before the tests completed");
    $display("TEST FAILED");
    $finish;
  end

  initial begin
    seed = 85;
    next_pc = 32'h8000_0000;
    errors = 0;
    checks = 0;
    tests_run = 0;
    done_pulses = 0;
    popped = 0;
    pop_en = 1'b0;
    uop_pop = 1'b0;
    inst_valid = 1'b0;
    inst = '0;
    rst_n = 1'b0;
    repeat (3) @(posedge clk);
    #1;
    rst_n = 1'b1;
    @(negedge clk);
    check_bit("inst_done", inst_done, 1'b0);
    check_bit("inst_illegal", inst_illegal, 1'b0);
    check_bit("uop_out_valid", uop_out_valid, 1'b0);
    check_bit("queue_full", queue_full, 1'b0);
    pop_en = 1'b1;

    test_unit_stride_frac();
    test_strided_store_bad_index();
    test_indexed_ordered();
    test_vstart_skip();
    test_illegal_cases();
    test_back_pressure();

    $display("tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
    if (errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule
